/* project.f */
+incdir+source
source/serdes_pkg.sv
source/serdes_csr.sv
source/serdes_link_ctrl.sv
source/serdes_tx.sv
source/serdes_rx.sv
source/io_serdes.sv
verif/io_serdes_properties.sv
verif/tb_io_serdes.sv

/* Makefile */
VERILATOR := verilator
TOP       := tb_io_serdes
FILELIST  := project.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR) --top-module $(TOP)
RUN_FLAGS := +verilator+error+limit+1000
PASS_MSG  := >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# Output goes to the console only, the exit status comes from the search
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* verif/tb_io_serdes.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_io_serdes;

  import serdes_pkg::*;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_BEATS    = 200;
  localparam int BP_BEATS     = 60;    // Sent across the stall
  localparam int SETUP_CYCLES = 600;   // Reset, registers, stall window, drain
  localparam int TICK_PERIOD  = 4;     // ioclk cycles per core tick
  localparam int WATCHDOG_NS  =
    ((NUM_BEATS + BP_BEATS) * 8 * 4 + SETUP_CYCLES) * CLK_PERIOD;
  localparam addr_t     CTRL_ADDR  = 15'h0000;
  localparam addr_t     OTHER_ADDR = 15'h0004;
  localparam axi_resp_t OKAY       = 2'b00;

  logic         ioclk = 1'b0;
  logic         axis_rst_n;
  logic         awvalid;
  addr_t        awaddr;
  logic         wvalid;
  data_t        wdata;
  strb_t        wstrb;
  logic         bready;
  logic         arvalid;
  addr_t        araddr;
  logic         rready;
  axis_beat_t   as_is;
  logic         as_is_tvalid;
  logic         as_is_tready;
  wire          awready;
  wire          wready;
  wire          bvalid;
  wire          arready;
  wire          rvalid;
  wire          is_as_tready;
  wire          core_tick;
  wire          is_as_tvalid;
  wire          axi_resp_t bresp;
  wire          axi_resp_t rresp;
  wire          data_t rdata;
  wire          axis_beat_t is_as;
  wire          lanes_t serial_loop;   // txd straight back into rxd

  axis_beat_t   accepted_q[$];
  logic         beat_taken = 1'b0;
  int           accepted_count = 0;
  int           received_count = 0;
  int           stream_errors = 0;
  int           reg_errors = 0;
  int           tick_gap = -1;   // Cycles since the last core tick

  always #(CLK_PERIOD / 2) ioclk = ~ioclk;

  io_serdes dut (
    .ioclk, .axis_rst_n,
    .awvalid, .awaddr, .awready, .wvalid, .wdata, .wstrb, .wready,
    .bvalid, .bresp, .bready,
    .arvalid, .araddr, .arready, .rvalid, .rdata, .rresp, .rready,
    .as_is, .as_is_tvalid, .as_is_tready, .is_as_tready, .core_tick,
    .serial_txd (serial_loop),
    .serial_rxd (serial_loop),
    .is_as, .is_as_tvalid
  );

  bind io_serdes io_serdes_properties u_props (
    .ioclk, .axis_rst_n, .txen, .core_tick, .serial_txd, .is_as_tvalid,
    .is_as_tready, .bvalid, .bready, .rvalid, .rready
  );

  //////////////////////////////////////////////////////////////////////
  // Reference model and compare

  // Transparent link, so the oldest accepted beat is the next one out
  function automatic axis_beat_t expect_beat();
    return accepted_q.pop_front();
  endfunction

  always @(negedge ioclk) begin : monitor
    axis_beat_t exp_beat;
    if (axis_rst_n) begin
      beat_taken = core_tick && as_is_tvalid && is_as_tready;   // Taken at next edge
      if (beat_taken) begin
        accepted_q.push_back(as_is);
        accepted_count++;
      end
      if (core_tick && is_as_tvalid) begin
        received_count++;
        assert (accepted_q.size() != 0) else begin
          $display("Extra beat on is_as at %0t with nothing accepted", $time);
          stream_errors++;
        end
        if (accepted_q.size() != 0) begin
          exp_beat = expect_beat();
          assert (is_as == exp_beat) else begin
            $display("MISMATCH at %0t: is_as got %h expected %h", $time, is_as, exp_beat);
            stream_errors++;
          end
        end
      end
    end
  end

  // One core tick in every TICK_PERIOD cycles
  always @(negedge ioclk) begin : tick_check
    if (!axis_rst_n) begin
      tick_gap = -1;
    end else if (core_tick) begin
      if (tick_gap >= 0) begin
        assert (tick_gap + 1 == TICK_PERIOD) else begin
          $display("MISMATCH at %0t: core_tick period got %0d expected %0d",
                   $time, tick_gap + 1, TICK_PERIOD);
          stream_errors++;
        end
      end
      tick_gap = 0;
    end else if (tick_gap >= 0) begin
      tick_gap++;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks

  task automatic expect_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      reg_errors++;
    end
  endtask

  task automatic axi_write(input addr_t addr, input data_t data);
    int waited;
    waited = 0;
    @(posedge ioclk);
    awvalid <= 1'b1;
    awaddr  <= addr;
    wvalid  <= 1'b1;
    wdata   <= data;
    wstrb   <= 4'hf;
    @(negedge ioclk);
    while (!(awready && wready) && waited < 16) begin
      waited++;
      @(negedge ioclk);
    end
    assert (awready && wready) else begin
      $display("AXI write to %h was never accepted", addr);
      reg_errors++;
    end
    @(posedge ioclk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    bready  <= 1'b1;
    @(negedge ioclk);                     // Response one cycle after acceptance
    expect_value("bvalid", 32'(bvalid), 32'h1);
    expect_value("bresp", 32'(bresp), 32'(OKAY));
    @(posedge ioclk);
    bready <= 1'b0;
  endtask

  task automatic check_reg(input addr_t addr, input data_t exp);
    int waited;
    waited = 0;
    @(posedge ioclk);
    arvalid <= 1'b1;
    araddr  <= addr;
    @(negedge ioclk);
    while (!arready && waited < 16) begin
      waited++;
      @(negedge ioclk);
    end
    assert (arready) else begin
      $display("AXI read of %h was never accepted", addr);
      reg_errors++;
    end
    @(posedge ioclk);
    arvalid <= 1'b0;
    rready  <= 1'b1;
    @(negedge ioclk);
    expect_value("rvalid", 32'(rvalid), 32'h1);
    expect_value("rresp", 32'(rresp), 32'(OKAY));
    expect_value("rdata", rdata, exp);
    @(posedge ioclk);
    rready <= 1'b0;
  endtask

  function automatic axis_beat_t random_beat();
    axis_beat_t b;
    b.tdata = $urandom();
    b.tstrb = strb_t'($urandom());
    b.tkeep = strb_t'($urandom());
    b.tid   = 2'($urandom());
    b.tuser = 2'($urandom());
    b.tlast = 1'($urandom());
    return b;
  endfunction

  // Holds each beat until taken, random idle frames in between
  task automatic send_beats(input int n);
    int sent;
    sent = 0;
    while (sent < n) begin
      @(posedge ioclk);
      if (beat_taken) begin
        sent++;
      end
      if (beat_taken || !as_is_tvalid) begin
        if (sent < n && ($urandom() % 4) != 0) begin
          as_is        <= random_beat();
          as_is_tvalid <= 1'b1;
        end else begin
          as_is_tvalid <= 1'b0;
        end
      end
    end
  endtask

  // Our own ready loops back as the partner's ready
  task automatic stall_partner();
    int ticks;
    ticks = 0;
    repeat (40) @(posedge ioclk);
    as_is_tready <= 1'b0;
    @(negedge ioclk);
    while (is_as_tready && ticks < 4) begin
      if (core_tick) begin
        ticks++;
      end
      @(negedge ioclk);
    end
    assert (!is_as_tready) else begin
      $display("is_as_tready still high %0d core ticks after as_is_tready fell", ticks);
      reg_errors++;
    end
    repeat (40) begin
      @(negedge ioclk);
      expect_value("is_as_tready", 32'(is_as_tready), 32'h0);
    end
    @(posedge ioclk);
    as_is_tready <= 1'b1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    int total;
    void'($urandom(12100));
    axis_rst_n   = 1'b0;
    awvalid      = 1'b0;
    awaddr       = '0;
    wvalid       = 1'b0;
    wdata        = '0;
    wstrb        = '0;
    bready       = 1'b0;
    arvalid      = 1'b0;
    araddr       = '0;
    rready       = 1'b0;
    as_is        = '0;
    as_is_tvalid = 1'b0;
    as_is_tready = 1'b1;
    repeat (RESET_CYCLES) @(posedge ioclk);
    axis_rst_n <= 1'b1;

    @(negedge ioclk);
    expect_value("awready", 32'(awready), 32'h0);
    expect_value("wready", 32'(wready), 32'h0);
    expect_value("bvalid", 32'(bvalid), 32'h0);
    expect_value("rvalid", 32'(rvalid), 32'h0);
    expect_value("is_as_tvalid", 32'(is_as_tvalid), 32'h0);
    expect_value("is_as_tready", 32'(is_as_tready), 32'h0);
    expect_value("serial_txd", 32'(serial_loop), 32'h0);

    axi_write(CTRL_ADDR, 32'h1);          // Receive only
    check_reg(CTRL_ADDR, 32'h1);
    axi_write(OTHER_ADDR, 32'hffff_ffff);
    check_reg(CTRL_ADDR, 32'h1);
    check_reg(OTHER_ADDR, 32'h0);
    repeat (40) begin
      @(negedge ioclk);
      expect_value("serial_txd", 32'(serial_loop), 32'h0);
      expect_value("is_as_tready", 32'(is_as_tready), 32'h0);
    end

    axi_write(CTRL_ADDR, 32'h3);
    check_reg(CTRL_ADDR, 32'h3);
    send_beats(NUM_BEATS);
    fork
      send_beats(BP_BEATS);
      stall_partner();
    join

    // Drain what is still on the link, then leave room for strays
    repeat (64) begin
      if (accepted_q.size() != 0) begin
        @(negedge ioclk);
      end
    end
    repeat (32) @(negedge ioclk);
    assert (accepted_q.size() == 0) else begin
      $display("%0d accepted beats never came out of the link", accepted_q.size());
      reg_errors++;
    end
    expect_value("received beats", received_count, accepted_count);

    total = reg_errors + stream_errors + int'(dut.u_props.fail_count);
    $display(
      "Summary: %0d control errors, %0d stream errors, %0d assertion failures, %0d/%0d beats",
      reg_errors, stream_errors, dut.u_props.fail_count, received_count, accepted_count);
    if (total == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0t before the test sequence finished", $time);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/io_serdes_properties.sv */
`timescale 1ns/1ns
`default_nettype none

`include "serdes_cfg.svh"

module io_serdes_properties (
  input wire                      ioclk,
  input wire                      axis_rst_n,
  input wire                      txen,
  input wire                      core_tick,
  input wire serdes_pkg::lanes_t  serial_txd,
  input wire                      is_as_tvalid,
  input wire                      is_as_tready,
  input wire                      bvalid,
  input wire                      bready,
  input wire                      rvalid,
  input wire                      rready
);

  import serdes_pkg::*;

  // Link tvalid sits just above the beat in the link word
  localparam int VALID_BIT   = $bits(axis_beat_t);
  localparam int VALID_LANE  = VALID_BIT / `SERDES_CLK_RATIO;
  localparam int VALID_SLOT  = VALID_BIT % `SERDES_CLK_RATIO;   // Phase that carries it
  localparam int VALID_DELAY = VALID_SLOT + 1;   // Cycles from the capture tick

  int unsigned fail_count = 0;   // Read by the testbench summary

  //////////////////////////////////////////////////////////////////////
  // Link rules

  a_txd_quiet: assert property (@(posedge ioclk) disable iff (!axis_rst_n)
      !txen |-> (serial_txd == '0))
    else begin
      $error("serial_txd active while txen is low");
      fail_count++;
    end

  a_valid_frame: assert property (@(posedge ioclk) disable iff (!axis_rst_n)
      $changed(is_as_tvalid) |-> $past(core_tick))
    else begin
      $error("is_as_tvalid moved away from a frame boundary");
      fail_count++;
    end

  // Ready low on a tick means the next word goes out with tvalid clear
  a_no_accept: assert property (@(posedge ioclk) disable iff (!axis_rst_n)
      $past(core_tick && !is_as_tready, VALID_DELAY) |-> !serial_txd[VALID_LANE])
    else begin
      $error("Link word marked valid although is_as_tready was low");
      fail_count++;
    end

  //////////////////////////////////////////////////////////////////////
  // AXI4-Lite response hold

  a_bvalid_hold: assert property (@(posedge ioclk) disable iff (!axis_rst_n)
      (bvalid && !bready) |=> bvalid)
    else begin
      $error("bvalid dropped before bready");
      fail_count++;
    end

  a_rvalid_hold: assert property (@(posedge ioclk) disable iff (!axis_rst_n)
      (rvalid && !rready) |=> rvalid)
    else begin
      $error("rvalid dropped before rready");
      fail_count++;
    end

endmodule

`default_nettype wire

/* source/io_serdes.sv */
`timescale 1ns/1ns
`default_nettype none

module io_serdes (
  input  wire                          ioclk,
  input  wire                          axis_rst_n,
  // AXI4-Lite slave
  input  wire                          awvalid,
  input  wire serdes_pkg::addr_t       awaddr,
  output wire                          awready,
  input  wire                          wvalid,
  input  wire serdes_pkg::data_t       wdata,
  input  wire serdes_pkg::strb_t       wstrb,
  output wire                          wready,
  output wire                          bvalid,
  output serdes_pkg::axi_resp_t        bresp,
  input  wire                          bready,
  input  wire                          arvalid,
  input  wire serdes_pkg::addr_t       araddr,
  output wire                          arready,
  output wire                          rvalid,
  output serdes_pkg::data_t            rdata,
  output serdes_pkg::axi_resp_t        rresp,
  input  wire                          rready,
  // Local stream into the link
  input  wire serdes_pkg::axis_beat_t  as_is,
  input  wire                          as_is_tvalid,
  input  wire                          as_is_tready,
  output wire                          is_as_tready,
  output wire                          core_tick,
  // Serial lanes
  output serdes_pkg::lanes_t           serial_txd,
  input  wire serdes_pkg::lanes_t      serial_rxd,
  // Local stream out of the link
  output serdes_pkg::axis_beat_t       is_as,
  output wire                          is_as_tvalid
);

  import serdes_pkg::*;

  phase_t phase;
  wire    rx_enable;
  wire    tx_enable;
  wire    txen;
  wire    rxen;
  wire    rx_active;
  wire    remote_tready;

  ///////////////////////////////////////////////////////////////////////
  // Control register and link sequencing

  serdes_csr u_csr (
    .ioclk, .axis_rst_n,
    .awvalid, .awaddr, .awready, .wvalid, .wdata, .wstrb, .wready,
    .bvalid, .bresp, .bready,
    .arvalid, .araddr, .arready, .rvalid, .rdata, .rresp, .rready,
    .rx_enable, .tx_enable
  );

  serdes_link_ctrl u_link_ctrl (
    .ioclk, .axis_rst_n,
    .rx_enable, .tx_enable, .rx_active, .remote_tready,
    .phase, .core_tick, .txen, .rxen, .is_as_tready
  );

  ///////////////////////////////////////////////////////////////////////
  // Data paths

  serdes_tx u_tx (
    .ioclk, .axis_rst_n, .phase, .core_tick, .txen,
    .as_is, .as_is_tvalid, .as_is_tready, .is_as_tready,
    .serial_txd
  );

  serdes_rx u_rx (
    .ioclk, .axis_rst_n, .phase, .rxen, .serial_rxd,
    .is_as, .is_as_tvalid, .remote_tready, .rx_active
  );

endmodule

`default_nettype wire

/* source/serdes_rx.sv */
`timescale 1ns/1ns
`default_nettype none

`include "serdes_cfg.svh"

module serdes_rx (
  input  wire                          ioclk,
  input  wire                          axis_rst_n,
  input  wire serdes_pkg::phase_t      phase,
  input  wire                          rxen,
  input  wire serdes_pkg::lanes_t      serial_rxd,
  output serdes_pkg::axis_beat_t       is_as,
  output logic                         is_as_tvalid,
  output logic                         remote_tready,
  output logic                         rx_active
);

  import serdes_pkg::*;

  localparam int RATIO = `SERDES_CLK_RATIO;

  // First RATIO-1 bits of each lane; the last one comes straight off the pin
  logic [`SERDES_LANES-1:0][RATIO-2:0] nib_sh;
  logic [`SERDES_LINK_W-1:0]           rx_bits;
  link_word_t                          rx_word;
  logic                                frame_end;

  assign frame_end = rxen && (phase == PHASE_LAST);

  always_ff @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      nib_sh <= '0;
    end else if (rxen) begin
      for (int j = 0; j < `SERDES_LANES; j++) begin
        nib_sh[j] <= {serial_rxd[j], nib_sh[j][RATIO-2:1]};   // LSB first
      end
    end
  end

  // Reassemble word in the phase-3 cycle
  always_comb begin
    for (int j = 0; j < `SERDES_LANES; j++) begin
      rx_bits[j*RATIO +: RATIO] = {serial_rxd[j], nib_sh[j]};
    end
  end

  assign rx_word = link_word_t'(rx_bits);

  ///////////////////////////////////////////////////////////////////////
  // Output registers, held for a whole frame

  always_ff @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      is_as_tvalid  <= 1'b0;
      remote_tready <= 1'b0;
      rx_active     <= 1'b0;
    end else if (frame_end) begin
      is_as_tvalid  <= rx_word.tvalid;
      remote_tready <= rx_word.tready;
      rx_active     <= rx_active || rx_word.tvalid || rx_word.tready;   // Sticky
    end
  end

  always_ff @(posedge ioclk) begin
    if (frame_end) begin
      is_as <= rx_word.beat;
    end
  end

endmodule

`default_nettype wire

/* source/serdes_tx.sv */
`timescale 1ns/1ns
`default_nettype none

`include "serdes_cfg.svh"

module serdes_tx (
  input  wire                          ioclk,
  input  wire                          axis_rst_n,
  input  wire serdes_pkg::phase_t      phase,
  input  wire                          core_tick,
  input  wire                          txen,
  // Local stream going out
  input  wire serdes_pkg::axis_beat_t  as_is,
  input  wire                          as_is_tvalid,
  input  wire                          as_is_tready,    // Our own ready, sent to partner
  input  wire                          is_as_tready,    // Ready as seen by the local switch
  output serdes_pkg::lanes_t           serial_txd
);

  import serdes_pkg::*;

  link_word_t tx_word;

  ///////////////////////////////////////////////////////////////////////
  // Capture at frame boundary

  // A beat counts only if the switch saw ready on this same tick
  always_ff @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      tx_word <= '0;
    end else if (core_tick && txen) begin
      tx_word.spare  <= '0;
      tx_word.tready <= as_is_tready;
      tx_word.tvalid <= as_is_tvalid && is_as_tready;
      tx_word.beat   <= as_is;
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // Lane serializer

  // Phase 0 follows the capture edge, so bit 0 of each nibble leads
  always_comb begin
    for (int j = 0; j < `SERDES_LANES; j++) begin
      serial_txd[j] = txen && tx_word[j*`SERDES_CLK_RATIO + phase];
    end
  end

endmodule

`default_nettype wire

/* source/serdes_link_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module serdes_link_ctrl (
  input  wire                  ioclk,
  input  wire                  axis_rst_n,
  input  wire                  rx_enable,
  input  wire                  tx_enable,
  input  wire                  rx_active,       // Partner has been heard from
  input  wire                  remote_tready,
  output serdes_pkg::phase_t   phase,
  output logic                 core_tick,
  output logic                 txen,
  output logic                 rxen,
  output logic                 is_as_tready
);

  import serdes_pkg::*;

  ///////////////////////////////////////////////////////////////////////
  // Frame phase, free running from reset

  always_ff @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      phase <= '0;
    end else if (core_tick) begin
      phase <= '0;
    end else begin
      phase <= phase + 1'b1;
    end
  end

  assign core_tick = (phase == PHASE_LAST);

  // Enables only ever set, cleared by reset alone
  always_ff @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      txen <= 1'b0;
      rxen <= 1'b0;
    end else begin
      // Partner talking first also brings tx up, so our ready reaches it
      if (core_tick && (tx_enable || rx_active)) begin
        txen <= 1'b1;
      end
      if (rx_enable) begin
        rxen <= 1'b1;
      end
    end
  end

  // Local ready, moves on core ticks only
  always_ff @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      is_as_tready <= 1'b0;
    end else if (core_tick) begin
      is_as_tready <= txen && (!rx_active || remote_tready);   // High until partner heard
    end
  end

endmodule

`default_nettype wire

/* source/serdes_csr.sv */
`timescale 1ns/1ns
`default_nettype none

`include "serdes_cfg.svh"

module serdes_csr (
  input  wire                          ioclk,
  input  wire                          axis_rst_n,
  // Write address and data
  input  wire                          awvalid,
  input  wire serdes_pkg::addr_t       awaddr,
  output logic                         awready,
  input  wire                          wvalid,
  input  wire serdes_pkg::data_t       wdata,
  input  wire serdes_pkg::strb_t       wstrb,
  output logic                         wready,
  // Write response
  output logic                         bvalid,
  output serdes_pkg::axi_resp_t        bresp,
  input  wire                          bready,
  // Read address and data
  input  wire                          arvalid,
  input  wire serdes_pkg::addr_t       araddr,
  output logic                         arready,
  output logic                         rvalid,
  output serdes_pkg::data_t            rdata,
  output serdes_pkg::axi_resp_t        rresp,
  input  wire                          rready,
  // Control bits
  output logic                         rx_enable,
  output logic                         tx_enable
);

  import serdes_pkg::*;

  localparam addr_t CTRL_ADDR = addr_t'(`SERDES_CSR_CTRL);

  logic wr_ready;   // AW and W accepted together
  logic wr_fire;
  logic rd_fire;
  logic wr_hit;
  logic rd_hit;

  assign awready = wr_ready;
  assign wready  = wr_ready;
  assign bresp   = RESP_OKAY;
  assign rresp   = RESP_OKAY;
  assign arready = !rvalid;   // One read in flight

  assign wr_fire = wr_ready && awvalid && wvalid;
  assign rd_fire = arvalid && arready;

  // Word compare, byte lanes ignored
  assign wr_hit = (awaddr[`SERDES_ADDR_W-1:2] == CTRL_ADDR[`SERDES_ADDR_W-1:2]) && wstrb[0];
  assign rd_hit = (araddr[`SERDES_ADDR_W-1:2] == CTRL_ADDR[`SERDES_ADDR_W-1:2]);

  ///////////////////////////////////////////////////////////////////////
  // Write path

  always_ff @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      wr_ready  <= 1'b0;
      bvalid    <= 1'b0;
      rx_enable <= 1'b0;
      tx_enable <= 1'b0;
    end else begin
      wr_ready <= awvalid && wvalid && !bvalid && !wr_ready;   // Single-cycle pulse
      if (wr_fire) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      if (wr_fire && wr_hit) begin
        rx_enable <= wdata[0];
        tx_enable <= wdata[1];
      end
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // Read path

  always_ff @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      rvalid <= 1'b0;
    end else if (rd_fire) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge ioclk) begin
    if (rd_fire) begin
      rdata <= rd_hit ? data_t'({tx_enable, rx_enable}) : '0;
    end
  end

endmodule

`default_nettype wire

/* source/serdes_pkg.sv */
`default_nettype none

`include "serdes_cfg.svh"

package serdes_pkg;

  typedef logic [`SERDES_DATA_W-1:0]             data_t;
  typedef logic [`SERDES_DATA_W/8-1:0]           strb_t;   // Strobe or keep
  typedef logic [`SERDES_ADDR_W-1:0]             addr_t;
  typedef logic [$clog2(`SERDES_CLK_RATIO)-1:0]  phase_t;  // Bit slot in a frame
  typedef logic [`SERDES_LANES-1:0]              lanes_t;
  typedef logic [1:0]                            axi_resp_t;

  localparam axi_resp_t RESP_OKAY = 2'b00;

  // Last bit slot, the one that carries core_tick
  localparam phase_t PHASE_LAST = phase_t'(`SERDES_CLK_RATIO - 1);

  ///////////////////////////////////////////////////////////////////////
  // Stream beat as it crosses the link

  typedef struct packed {
    data_t      tdata;
    strb_t      tstrb;
    strb_t      tkeep;
    logic [1:0] tid;
    logic [1:0] tuser;
    logic       tlast;
  } axis_beat_t;

  // Lane j carries bits 4j..4j+3, lowest first
  typedef struct packed {
    logic [`SERDES_LINK_W-$bits(axis_beat_t)-3:0] spare;   // Always zero
    logic       tready;   // Sender's own ready
    logic       tvalid;   // Only set for accepted beats
    axis_beat_t beat;
  } link_word_t;

endpackage

`default_nettype wire

/* source/serdes_cfg.svh */
`ifndef SERDES_CFG_SVH
`define SERDES_CFG_SVH

// Stream side
`define SERDES_DATA_W     32

// Serial bits per lane in one core tick
`define SERDES_CLK_RATIO  4

// Lane count on the link
`define SERDES_LANES      12

// Full link word, one nibble per lane
`define SERDES_LINK_W     (`SERDES_LANES * `SERDES_CLK_RATIO)

// AXI4-Lite register space
`define SERDES_ADDR_W     15

// Control register offset (bit 0 rx enable, bit 1 tx enable)
`define SERDES_CSR_CTRL   0

`endif
